// ==== flist.f ====
+incdir+include
hdl/chiplet_types_pkg.sv
hdl/endpoint_cfg_pkg.sv
hdl/flit_counter.sv
hdl/crc32_engine.sv
hdl/tx_fifo.sv
hdl/msg_table_wb.sv
hdl/tx_fsm.sv
hdl/chiplet_tx_top.sv
verif/tb_chiplet_tx.sv

// ==== hdl/chiplet_tx_top.sv ====
`timescale 1ns/1ps

module chiplet_tx_top import chiplet_types_pkg::*, endpoint_cfg_pkg::*; (
    input  logic    clk,
    input  logic    n_rst,
    input  wb_m2s_t wb_in,
    output wb_s2m_t wb_out,
    output flit_t   flit,
    output logic    flit_valid,
    input  logic    buffer_available
);

    logic [NUM_MSGS-1:0] trigger_send;
    node_id_t            node_id;
    logic                pkt_taken;
    pkt_id_t             pkt_taken_id;
    logic                busy;
    logic                fifo_wen;
    logic                fifo_ren;
    logic                fifo_full;
    logic                fifo_empty;
    word_t               fifo_wdata;
    word_t               fifo_rdata;
    pkt_length_t         fifo_count;

    msg_table_wb u_msg_table (
        .clk         (clk),
        .n_rst       (n_rst),
        .wb_in       (wb_in),
        .wb_out      (wb_out),
        .trigger_send(trigger_send),
        .node_id     (node_id),
        .pkt_taken   (pkt_taken),
        .pkt_taken_id(pkt_taken_id),
        .fifo_wen    (fifo_wen),
        .fifo_wdata  (fifo_wdata),
        .fifo_full   (fifo_full),
        .fifo_count  (fifo_count),
        .busy        (busy)
    );

    tx_fifo #(
        .DEPTH(TX_FIFO_DEPTH)
    ) u_tx_fifo (
        .clk  (clk),
        .n_rst(n_rst),
        .wen  (fifo_wen),
        .wdata(fifo_wdata),
        .ren  (fifo_ren),
        .rdata(fifo_rdata),
        .count(fifo_count),
        .full (fifo_full),
        .empty(fifo_empty)
    );

    tx_fsm u_tx_fsm (
        .clk             (clk),
        .n_rst           (n_rst),
        .trigger_send    (trigger_send),
        .node_id         (node_id),
        .pkt_taken       (pkt_taken),
        .pkt_taken_id    (pkt_taken_id),
        .busy            (busy),
        .fifo_rdata      (fifo_rdata),
        .fifo_empty      (fifo_empty),
        .fifo_ren        (fifo_ren),
        .buffer_available(buffer_available),
        .flit            (flit),
        .flit_valid      (flit_valid)
    );

endmodule

// ==== hdl/chiplet_types_pkg.sv ====
package chiplet_types_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  node_id_t;
    typedef logic [1:0]  pkt_id_t;

    localparam int NUM_MSGS         = 4;
    localparam int PKT_LENGTH_WIDTH = 5;

    typedef logic [PKT_LENGTH_WIDTH-1:0] pkt_length_t;

    typedef enum logic [3:0] {
        FMT_LONG_READ  = 4'h1,
        FMT_LONG_WRITE = 4'h2,
        FMT_SWITCH_CFG = 4'h8
    } format_e;

    // first word of every packet.
    typedef struct packed {
        format_e     format;
        logic [3:0]  length;
        node_id_t    dest;
        logic [19:0] addr;
    } long_hdr_t;

    typedef struct packed {
        logic     vc;
        pkt_id_t  id;
        node_id_t req;
    } flit_meta_t;

    typedef struct packed {
        flit_meta_t metadata;
        word_t      payload;
    } flit_t;

    // fifo words in a packet, header included.
    function automatic pkt_length_t expected_num_flits(word_t hdr_word);
        long_hdr_t hdr;
        hdr = long_hdr_t'(hdr_word);
        if (hdr.format == FMT_SWITCH_CFG) begin
            return pkt_length_t'(2);
        end
        return pkt_length_t'(hdr.length) + 1'b1;
    endfunction

endpackage

// ==== hdl/crc32_engine.sv ====
`timescale 1ns/1ps

module crc32_engine import chiplet_types_pkg::*, endpoint_cfg_pkg::*; (
    input  logic  clk,
    input  logic  n_rst,
    input  logic  clear,
    input  logic  update,
    input  word_t in,
    output word_t crc_out,
    output logic  done
);

    logic [2:0] steps_left;
    word_t      shift_q;

    // one byte through the polynomial, msb first.
    function automatic word_t crc_byte(word_t crc, logic [7:0] data);
        word_t c;
        c = crc ^ {data, 24'd0};
        for (int i = 0; i < 8; i++) begin
            c = c[31] ? ((c << 1) ^ CRC_POLY) : (c << 1);
        end
        return c;
    endfunction

    assign done = (steps_left == 3'd0);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            crc_out    <= CRC_INIT;
            steps_left <= 3'd0;
        end else if (clear) begin
            crc_out    <= CRC_INIT;
            steps_left <= 3'd0;
        end else if (update) begin
            // four bytes per word.
            steps_left <= 3'd4;
        end else if (!done) begin
            crc_out    <= crc_byte(crc_out, shift_q[31:24]);
            steps_left <= steps_left - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (update) begin
            shift_q <= in;
        end else if (!done) begin
            shift_q <= shift_q << 8;
        end
    end

endmodule

// ==== hdl/endpoint_cfg_pkg.sv ====
package endpoint_cfg_pkg;

    import chiplet_types_pkg::*;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [15:0] adr;
        word_t       dat;
        logic [3:0]  sel;
    } wb_m2s_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_s2m_t;

    // register map.
    localparam logic [15:0] ADDR_TRIGGER = 16'h1000;
    localparam logic [15:0] ADDR_TX_SEND = 16'h1004;
    localparam logic [15:0] ADDR_NODE_ID = 16'h1008;
    localparam logic [15:0] ADDR_STATUS  = 16'h100C;

    localparam int TX_FIFO_DEPTH    = 16;
    localparam int DOWNSTREAM_DEPTH = 8;
    localparam int SEND_LIMIT       = DOWNSTREAM_DEPTH * 3 / 4;

    localparam word_t CRC_POLY = 32'h04C11DB7;
    localparam word_t CRC_INIT = 32'hFFFFFFFF;

endpackage

// ==== hdl/flit_counter.sv ====
`timescale 1ns/1ps

module flit_counter import chiplet_types_pkg::*; #(
    parameter int NBITS = PKT_LENGTH_WIDTH
) (
    input  logic             clk,
    input  logic             n_rst,
    input  logic             clear,
    input  logic             count_enable,
    input  logic [NBITS-1:0] overflow_val,
    output logic [NBITS-1:0] count_out,
    output logic             overflow_flag
);

    assign overflow_flag = (count_out == overflow_val);

    // count holds once it reaches overflow_val.
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            count_out <= '0;
        end else if (clear) begin
            count_out <= '0;
        end else if (count_enable && !overflow_flag) begin
            count_out <= count_out + 1'b1;
        end
    end

endmodule

// ==== hdl/msg_table_wb.sv ====
`timescale 1ns/1ps

module msg_table_wb import chiplet_types_pkg::*, endpoint_cfg_pkg::*; (
    input  logic                clk,
    input  logic                n_rst,
    input  wb_m2s_t             wb_in,
    output wb_s2m_t             wb_out,
    output logic [NUM_MSGS-1:0] trigger_send,
    output node_id_t            node_id,
    input  logic                pkt_taken,
    input  pkt_id_t             pkt_taken_id,
    output logic                fifo_wen,
    output word_t               fifo_wdata,
    input  logic                fifo_full,
    input  pkt_length_t         fifo_count,
    input  logic                busy
);

    logic                request;
    logic                send_stall;
    logic                accept;
    logic                wr_accept;
    logic                ack_q;
    word_t               rdat_q;
    word_t               read_mux;
    logic [NUM_MSGS-1:0] set_mask;
    logic [NUM_MSGS-1:0] clr_mask;

    ////////////////////////////////////////////////////////////
    // bus decode
    ////////////////////////////////////////////////////////////

    assign request = wb_in.cyc && wb_in.stb;

    // hold off the ack while the fifo is full.
    assign send_stall = wb_in.we && (wb_in.adr == ADDR_TX_SEND) && fifo_full;
    assign accept     = request && !ack_q && !send_stall;
    assign wr_accept  = accept && wb_in.we;

    assign fifo_wen   = wr_accept && (wb_in.adr == ADDR_TX_SEND);
    assign fifo_wdata = wb_in.dat;

    always_comb begin
        read_mux = '0;
        case (wb_in.adr)
            ADDR_TRIGGER: read_mux[NUM_MSGS-1:0] = trigger_send;
            ADDR_NODE_ID: read_mux[$bits(node_id_t)-1:0] = node_id;
            ADDR_STATUS: begin
                read_mux[PKT_LENGTH_WIDTH-1:0] = fifo_count;
                read_mux[8] = busy;
            end
            default: read_mux = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // registers
    ////////////////////////////////////////////////////////////

    always_comb begin
        set_mask = '0;
        clr_mask = '0;
        if (wr_accept && (wb_in.adr == ADDR_TRIGGER)) begin
            set_mask = wb_in.dat[NUM_MSGS-1:0];
        end
        if (pkt_taken) begin
            clr_mask[pkt_taken_id] = 1'b1;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            ack_q        <= 1'b0;
            trigger_send <= '0;
            node_id      <= '0;
        end else begin
            ack_q        <= accept;
            // a new trigger beats a clear of the same slot.
            trigger_send <= (trigger_send & ~clr_mask) | set_mask;
            if (wr_accept && (wb_in.adr == ADDR_NODE_ID)) begin
                node_id <= wb_in.dat[$bits(node_id_t)-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rdat_q <= read_mux;
        end
    end

    assign wb_out = '{ack: ack_q, dat: rdat_q};

endmodule

// ==== hdl/tx_fifo.sv ====
`timescale 1ns/1ps

module tx_fifo import chiplet_types_pkg::*, endpoint_cfg_pkg::*; #(
    parameter int DEPTH = TX_FIFO_DEPTH
) (
    input  logic        clk,
    input  logic        n_rst,
    input  logic        wen,
    input  word_t       wdata,
    input  logic        ren,
    output word_t       rdata,
    output pkt_length_t count,
    output logic        full,
    output logic        empty
);

    typedef logic [$clog2(DEPTH)-1:0] ptr_t;

    word_t mem [DEPTH];
    ptr_t  wptr;
    ptr_t  rptr;
    logic  do_write;
    logic  do_read;

    function automatic ptr_t next_ptr(ptr_t p);
        return (p == ptr_t'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full     = (count == pkt_length_t'(DEPTH));
    assign empty    = (count == '0);
    assign do_write = wen && !full;
    assign do_read  = ren && !empty;

    // head word is visible before the pop.
    assign rdata = mem[rptr];

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wptr] <= wdata;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                wptr <= next_ptr(wptr);
            end
            if (do_read) begin
                rptr <= next_ptr(rptr);
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== hdl/tx_fsm.sv ====
`timescale 1ns/1ps

module tx_fsm import chiplet_types_pkg::*, endpoint_cfg_pkg::*; (
    input  logic                clk,
    input  logic                n_rst,
    input  logic [NUM_MSGS-1:0] trigger_send,
    input  node_id_t            node_id,
    output logic                pkt_taken,
    output pkt_id_t             pkt_taken_id,
    output logic                busy,
    input  word_t               fifo_rdata,
    input  logic                fifo_empty,
    output logic                fifo_ren,
    input  logic                buffer_available,
    output flit_t               flit,
    output logic                flit_valid
);

    typedef enum logic [1:0] {
        IDLE,
        START_SEND_PKT,
        SEND_PKT,
        CRC
    } tx_state_e;

    tx_state_e   state;
    tx_state_e   next_state;
    pkt_id_t     curr_id;
    pkt_id_t     pick_id;
    format_e     curr_fmt;
    pkt_length_t target_len;
    long_hdr_t   head_hdr;
    logic        crc_loaded;
    logic        length_clear;
    logic        length_done;
    logic        stop_sending;
    logic        can_go;
    logic        crc_update;
    logic        emit_word;
    logic        crc_done;
    word_t       crc_out;

    assign head_hdr     = long_hdr_t'(fifo_rdata);
    assign busy         = (state != IDLE);
    assign length_clear = (state == IDLE);
    assign can_go       = !stop_sending && !length_done && !fifo_empty;
    assign fifo_ren     = emit_word;
    assign pkt_taken_id = pick_id;

    ////////////////////////////////////////////////////////////
    // counters and crc
    ////////////////////////////////////////////////////////////

    flit_counter #(
        .NBITS(PKT_LENGTH_WIDTH)
    ) length_counter (
        .clk          (clk),
        .n_rst        (n_rst),
        .clear        (length_clear),
        .count_enable (emit_word),
        .overflow_val (target_len),
        .count_out    (),
        .overflow_flag(length_done)
    );

    // credits come back with buffer_available.
    flit_counter #(
        .NBITS(PKT_LENGTH_WIDTH)
    ) send_counter (
        .clk          (clk),
        .n_rst        (n_rst),
        .clear        (buffer_available),
        .count_enable (flit_valid),
        .overflow_val (pkt_length_t'(SEND_LIMIT)),
        .count_out    (),
        .overflow_flag(stop_sending)
    );

    crc32_engine crc_gen (
        .clk    (clk),
        .n_rst  (n_rst),
        .clear  (length_clear),
        .update (crc_update),
        .in     (fifo_rdata),
        .crc_out(crc_out),
        .done   (crc_done)
    );

    ////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////

    // highest triggered slot wins.
    always_comb begin
        pick_id = '0;
        for (int i = 0; i < NUM_MSGS; i++) begin
            if (trigger_send[i]) begin
                pick_id = pkt_id_t'(i);
            end
        end
    end

    always_comb begin
        next_state = state;
        pkt_taken  = 1'b0;
        crc_update = 1'b0;
        emit_word  = 1'b0;
        flit_valid = 1'b0;
        case (state)
            IDLE: begin
                if (|trigger_send && !fifo_empty) begin
                    pkt_taken  = 1'b1;
                    next_state = START_SEND_PKT;
                end
            end
            START_SEND_PKT: begin
                next_state = SEND_PKT;
            end
            SEND_PKT: begin
                // absorb the word first, emit it once the crc is done.
                crc_update = can_go && crc_done && !crc_loaded;
                emit_word  = can_go && crc_done && crc_loaded;
                flit_valid = emit_word;
                if (length_done) begin
                    next_state = (curr_fmt == FMT_SWITCH_CFG) ? IDLE : CRC;
                end
            end
            CRC: begin
                flit_valid = !stop_sending;
                if (!stop_sending) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_comb begin
        flit.metadata.vc  = 1'b0;
        flit.metadata.id  = curr_id;
        flit.metadata.req = node_id;
        flit.payload      = (state == CRC) ? crc_out : fifo_rdata;
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state      <= IDLE;
            curr_id    <= '0;
            curr_fmt   <= FMT_LONG_READ;
            target_len <= '0;
            crc_loaded <= 1'b0;
        end else begin
            state <= next_state;
            if (pkt_taken) begin
                curr_id <= pick_id;
            end
            if (state == START_SEND_PKT) begin
                curr_fmt   <= head_hdr.format;
                target_len <= expected_num_flits(fifo_rdata);
            end
            if (crc_update) begin
                crc_loaded <= 1'b1;
            end else if (emit_word || (state == IDLE)) begin
                crc_loaded <= 1'b0;
            end
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the chiplet transmit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_chiplet_tx -f flist.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== include/chiplet_tx_ref.svh ====
`ifndef CHIPLET_TX_REF_SVH
`define CHIPLET_TX_REF_SVH

// bit-serial crc-32 over a list of words.
function automatic chiplet_types_pkg::word_t crc32_of_words(
    input chiplet_types_pkg::word_t words[$]
);
    chiplet_types_pkg::word_t crc;
    crc = endpoint_cfg_pkg::CRC_INIT;
    foreach (words[w]) begin
        for (int b = 31; b >= 0; b--) begin
            if (crc[31] ^ words[w][b]) begin
                crc = (crc << 1) ^ endpoint_cfg_pkg::CRC_POLY;
            end else begin
                crc = crc << 1;
            end
        end
    end
    return crc;
endfunction

function automatic chiplet_types_pkg::flit_t flit_with_meta(
    input chiplet_types_pkg::word_t    payload,
    input chiplet_types_pkg::pkt_id_t  id,
    input chiplet_types_pkg::node_id_t node
);
    chiplet_types_pkg::flit_t f;
    f.metadata.vc  = 1'b0;
    f.metadata.id  = id;
    f.metadata.req = node;
    f.payload      = payload;
    return f;
endfunction

// expected flits for one packet, words[0] being its header.
function automatic void expected_flit_list(
    input  chiplet_types_pkg::word_t    words[$],
    input  chiplet_types_pkg::pkt_id_t  id,
    input  chiplet_types_pkg::node_id_t node,
    output chiplet_types_pkg::flit_t    flits[$]
);
    chiplet_types_pkg::word_t     pkt_words[$];
    chiplet_types_pkg::long_hdr_t hdr;
    int                           n;
    flits = {};
    hdr = chiplet_types_pkg::long_hdr_t'(words[0]);
    // switch-config packets hold two words whatever the length field says.
    if (hdr.format == chiplet_types_pkg::FMT_SWITCH_CFG) begin
        n = 2;
    end else begin
        n = int'(hdr.length) + 1;
    end
    for (int i = 0; i < n && i < words.size(); i++) begin
        pkt_words.push_back(words[i]);
        flits.push_back(flit_with_meta(words[i], id, node));
    end
    if (hdr.format != chiplet_types_pkg::FMT_SWITCH_CFG) begin
        flits.push_back(flit_with_meta(crc32_of_words(pkt_words), id, node));
    end
endfunction

`endif

// ==== verif/tb_chiplet_tx.sv ====
`timescale 1ns/1ps

module tb_chiplet_tx import chiplet_types_pkg::*, endpoint_cfg_pkg::*; ();

    localparam int SEED          = 53;
    localparam int ACK_LIMIT     = 500;
    localparam int CREDIT_PERIOD = 8;
    localparam int PLAIN_ACK_WAIT = 2;

    // payload lengths of the queued packets.
    localparam int LEN_T2  = 5;
    localparam int LEN_T3  = 3;
    localparam int LEN_T4A = 2;
    localparam int LEN_T4B = 3;
    localparam int LEN_T5  = 8;
    localparam int LEN_T6A = 15;
    localparam int LEN_T6B = 3;

    // switch-config packets always hold two words.
    localparam int QUEUED_WORDS = (LEN_T2 + 1) + 2 + (LEN_T4A + 1) + (LEN_T4B + 1)
                                + (LEN_T5 + 1) + (LEN_T6A + 1) + (LEN_T6B + 1);
    localparam int WATCHDOG_CYCLES = 200 * QUEUED_WORDS + 1000;

    logic    clk = 1'b0;
    logic    n_rst;
    wb_m2s_t wb_in;
    wb_s2m_t wb_out;
    flit_t   flit;
    logic    flit_valid;
    logic    buffer_available;

    flit_t exp_q[$];
    flit_t got_q[$];
    int    cmp_idx     = 0;
    int    checks      = 0;
    int    mismatches  = 0;
    int    failures    = 0;
    logic  auto_credit = 1'b1;
    int    pulse_req   = 0;
    int    pulse_done  = 0;
    int    req_seen    = 0;
    logic  auto_seen   = 1'b1;
    int    credit_tick = 0;

    `include "chiplet_tx_ref.svh"

    chiplet_tx_top DUT (
        .clk             (clk),
        .n_rst           (n_rst),
        .wb_in           (wb_in),
        .wb_out          (wb_out),
        .flit            (flit),
        .flit_valid      (flit_valid),
        .buffer_available(buffer_available)
    );

    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // checking helpers
    ////////////////////////////////////////////////////////////

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        failures++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic compare_flit(input int idx, input flit_t got, input flit_t exp);
        check($sformatf("flit[%0d].payload", idx), got.payload, exp.payload);
        check($sformatf("flit[%0d].vc", idx), got.metadata.vc, exp.metadata.vc);
        check($sformatf("flit[%0d].id", idx), got.metadata.id, exp.metadata.id);
        check($sformatf("flit[%0d].req", idx), got.metadata.req, exp.metadata.req);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    ////////////////////////////////////////////////////////////
    // wishbone master
    ////////////////////////////////////////////////////////////

    // starts and ends one time unit after a rising edge.
    task automatic wb_cycle(input logic write_en, input logic [15:0] adr, input word_t dat,
                            output word_t rdat, output int waited);
        wb_in.cyc = 1'b1;
        wb_in.stb = 1'b1;
        wb_in.we  = write_en;
        wb_in.adr = adr;
        wb_in.dat = dat;
        wb_in.sel = 4'hF;
        @(posedge clk);
        #1;
        waited = 1;
        while (!wb_out.ack && waited < ACK_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!wb_out.ack) begin
            report_failure($sformatf("no Wishbone ack for address 0x%h", adr));
        end
        rdat  = wb_out.dat;
        wb_in = '0;
    endtask

    task automatic wb_write(input logic [15:0] adr, input word_t dat);
        word_t rdat;
        int    waited;
        wb_cycle(1'b1, adr, dat, rdat, waited);
    endtask

    task automatic wb_read(input logic [15:0] adr, output word_t rdat);
        int waited;
        wb_cycle(1'b0, adr, '0, rdat, waited);
    endtask

    ////////////////////////////////////////////////////////////
    // packets
    ////////////////////////////////////////////////////////////

    function automatic word_t make_header(input format_e fmt, input int len);
        long_hdr_t hdr;
        hdr.format = fmt;
        hdr.length = 4'(len);
        hdr.dest   = node_id_t'($urandom());
        hdr.addr   = 20'($urandom());
        return word_t'(hdr);
    endfunction

    // expected flits go in before the words reach the fifo.
    task automatic queue_packet(input format_e fmt, input int len, input pkt_id_t id,
                                input node_id_t node, output int max_wait);
        word_t words[$];
        flit_t flits[$];
        word_t rdat;
        int    waited;
        int    num_words;
        max_wait  = 0;
        num_words = (fmt == FMT_SWITCH_CFG) ? 2 : len + 1;
        words.push_back(make_header(fmt, len));
        for (int i = 1; i < num_words; i++) begin
            words.push_back($urandom());
        end
        expected_flit_list(words, id, node, flits);
        foreach (flits[i]) begin
            exp_q.push_back(flits[i]);
        end
        foreach (words[i]) begin
            wb_cycle(1'b1, ADDR_TX_SEND, words[i], rdat, waited);
            if (waited > max_wait) begin
                max_wait = waited;
            end
        end
    endtask

    task automatic wait_drained(input int max_cycles);
        int n;
        n = 0;
        while (cmp_idx < exp_q.size() && n < max_cycles) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (cmp_idx < exp_q.size()) begin
            report_failure($sformatf("%0d expected flits never arrived", exp_q.size() - cmp_idx));
        end
        // quiet period to catch stray flits.
        idle_cycles(20);
    endtask

    task automatic wait_flits(input int total, input int max_cycles);
        int n;
        n = 0;
        while (got_q.size() < total && n < max_cycles) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (got_q.size() < total) begin
            report_failure($sformatf("only %0d of %0d flits arrived", got_q.size(), total));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    task automatic reset_defaults();
        word_t rdat;
        check("flit_valid", flit_valid, 1'b0);
        check("wb_out.ack", wb_out.ack, 1'b0);
        wb_read(ADDR_STATUS, rdat);
        check("status.count", rdat[4:0], 0);
        check("status.busy", rdat[8], 1'b0);
    endtask

    task automatic long_write_packet(input node_id_t node);
        int max_wait;
        wb_write(ADDR_NODE_ID, word_t'(node));
        queue_packet(FMT_LONG_WRITE, LEN_T2, 2'd1, node, max_wait);
        wb_write(ADDR_TRIGGER, 32'h2);
        wait_drained(200 * (LEN_T2 + 2));
    endtask

    task automatic switch_cfg_packet(input node_id_t node);
        int max_wait;
        int base;
        base = got_q.size();
        queue_packet(FMT_SWITCH_CFG, LEN_T3, 2'd2, node, max_wait);
        wb_write(ADDR_TRIGGER, 32'h4);
        wait_drained(400);
        check("switch-config flit count", got_q.size() - base, 2);
    endtask

    task automatic slot_priority(input node_id_t node);
        word_t rdat;
        int    max_wait;
        // slot 3 outranks slot 0, so the fifo head goes out as id 3.
        queue_packet(FMT_LONG_WRITE, LEN_T4A, 2'd3, node, max_wait);
        queue_packet(FMT_LONG_READ, LEN_T4B, 2'd0, node, max_wait);
        wb_write(ADDR_TRIGGER, 32'h9);
        wait_drained(200 * (LEN_T4A + LEN_T4B + 4));
        wb_read(ADDR_TRIGGER, rdat);
        check("trigger_send", rdat[3:0], 0);
    endtask

    task automatic credit_stall(input node_id_t node);
        int max_wait;
        int base;
        auto_credit = 1'b0;
        pulse_req++;
        idle_cycles(4);
        base = got_q.size();
        queue_packet(FMT_LONG_WRITE, LEN_T5, 2'd2, node, max_wait);
        wb_write(ADDR_TRIGGER, 32'h4);
        wait_flits(base + SEND_LIMIT, 200 * SEND_LIMIT);
        idle_cycles(100);
        check("flits before buffer_available", got_q.size() - base, SEND_LIMIT);
        pulse_req++;
        wait_drained(200 * (LEN_T5 + 2));
        auto_credit = 1'b1;
    endtask

    task automatic fifo_backpressure(input node_id_t node);
        word_t rdat;
        int    max_wait;
        wb_write(ADDR_NODE_ID, word_t'(node));
        wb_read(ADDR_NODE_ID, rdat);
        check("node_id", rdat[3:0], node);
        // a 15-word payload plus header fills the fifo exactly.
        queue_packet(FMT_LONG_WRITE, LEN_T6A, 2'd2, node, max_wait);
        wb_read(ADDR_STATUS, rdat);
        check("status.count", rdat[4:0], TX_FIFO_DEPTH);
        wb_write(ADDR_TRIGGER, 32'h4);
        queue_packet(FMT_LONG_WRITE, LEN_T6B, 2'd1, node, max_wait);
        if (max_wait <= PLAIN_ACK_WAIT) begin
            report_failure("write to a full FIFO was acked before any word was popped");
        end
        wb_write(ADDR_TRIGGER, 32'h2);
        wait_drained(200 * (LEN_T6A + LEN_T6B + 4));
    endtask

    ////////////////////////////////////////////////////////////
    // processes
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (n_rst && flit_valid) begin
            got_q.push_back(flit);
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            while (cmp_idx < got_q.size()) begin
                if (cmp_idx < exp_q.size()) begin
                    compare_flit(cmp_idx, got_q[cmp_idx], exp_q[cmp_idx]);
                end else begin
                    report_failure($sformatf("unexpected flit 0x%h", got_q[cmp_idx]));
                end
                cmp_idx++;
            end
        end
    end

    // downstream credits, periodic or on request.
    initial begin
        buffer_available = 1'b0;
        forever begin
            @(posedge clk);
            req_seen  = pulse_req;
            auto_seen = auto_credit;
            #1;
            if (req_seen != pulse_done) begin
                buffer_available = 1'b1;
                pulse_done++;
            end else if (auto_seen && credit_tick == 0) begin
                buffer_available = 1'b1;
            end else begin
                buffer_available = 1'b0;
            end
            credit_tick = (credit_tick + 1) % CREDIT_PERIOD;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Error at %0t: watchdog expired after %0d cycles", $time, WATCHDOG_CYCLES);
        $display("checks: %0d, mismatches: %0d, other errors: %0d", checks, mismatches,
                 failures + 1);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        n_rst = 1'b0;
        wb_in = '0;
        repeat (10) @(posedge clk);
        #1;
        n_rst = 1'b1;
        idle_cycles(2);
        reset_defaults();
        long_write_packet(4'h5);
        switch_cfg_packet(4'h5);
        slot_priority(4'h5);
        credit_stall(4'h5);
        fifo_backpressure(4'hC);
        $display("checks: %0d, mismatches: %0d, other errors: %0d", checks, mismatches,
                 failures);
        if (mismatches == 0 && failures == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
